// File: build.f
verilog/sys_defs_pkg.sv
verilog/decoder.sv
verilog/imm_gen.sv
verilog/id_stage.sv
testbench/clock_gen.sv
testbench/id_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator, runs it and checks the log.
set -eo pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--timescale 1ns/100ps \
	--top-module id_stage_tb \
	-f build.f \
	-o sim_id_stage

./obj_dir/sim_id_stage | tee "$LOG"

if grep -q "Simulation failed" "$LOG"; then
	echo "run_sim: failure reported, see $LOG"
	exit 1
fi

echo "run_sim: no failure reported"

// File: testbench/clock_gen.sv
// testbench clock and reset source
// 4 ns clock, synchronous reset held high for the first 8 rising edges

`default_nettype none

module clock_gen (
	output logic clock,
	output logic reset
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// File: testbench/id_stage_tb.sv
// testbench for the rv32im decode stage
// directed and random words against a reference decode model, checked by assertions

`default_nettype none

module id_stage_tb
	import sys_defs_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	// 600 random words with short stalls plus directed cases end near 1000 cycles
	localparam int NUM_RANDOM  = 600;
	localparam int CYCLE_LIMIT = 2000;

	logic                  clock;
	logic                  reset;
	logic [31:0]           if_inst;
	logic [XLEN-1:0]       if_pc;
	logic                  if_valid;
	logic                  stall;

	// dut outputs
	logic                  id_valid;
	logic [XLEN-1:0]       id_pc;
	logic [OPA_W-1:0]      id_opa_select;
	logic [OPB_W-1:0]      id_opb_select;
	logic [ALU_W-1:0]      id_alu_func;
	logic [FU_W-1:0]       id_fu_type;
	logic [REG_IDX_W-1:0]  id_rs1_idx;
	logic [REG_IDX_W-1:0]  id_rs2_idx;
	logic [REG_IDX_W-1:0]  id_dest_reg_idx;
	logic [2:0]            id_funct3;
	logic [XLEN-1:0]       id_imm;
	logic                  id_rd_mem;
	logic                  id_wr_mem;
	logic                  id_cond_branch;
	logic                  id_uncond_branch;
	logic                  id_csr_op;
	logic                  id_halt;
	logic                  id_illegal;

	// one-deep expected id/ex register, same shape as the outputs
	logic                  exp_valid;
	logic [XLEN-1:0]       exp_pc;
	logic [OPA_W-1:0]      exp_opa;
	logic [OPB_W-1:0]      exp_opb;
	logic [ALU_W-1:0]      exp_alu;
	logic [FU_W-1:0]       exp_fu;
	logic [REG_IDX_W-1:0]  exp_rs1;
	logic [REG_IDX_W-1:0]  exp_rs2;
	logic [REG_IDX_W-1:0]  exp_dest;
	logic [2:0]            exp_funct3;
	logic [XLEN-1:0]       exp_imm;
	logic                  exp_rd_mem;
	logic                  exp_wr_mem;
	logic                  exp_cond;
	logic                  exp_uncond;
	logic                  exp_csr;
	logic                  exp_halt;
	logic                  exp_illegal;

	int                    errors = 0;
	int                    words = 0;
	int                    cycles = 0;
	logic [31:0]           lfsr_state = 32'h8e633f31;

	clock_gen u_clock_gen (
		.clock (clock),
		.reset (reset)
	);

	id_stage dut (
		.clock            (clock),
		.reset            (reset),
		.if_inst          (if_inst),
		.if_pc            (if_pc),
		.if_valid         (if_valid),
		.stall            (stall),
		.id_valid         (id_valid),
		.id_pc            (id_pc),
		.id_opa_select    (id_opa_select),
		.id_opb_select    (id_opb_select),
		.id_alu_func      (id_alu_func),
		.id_fu_type       (id_fu_type),
		.id_rs1_idx       (id_rs1_idx),
		.id_rs2_idx       (id_rs2_idx),
		.id_dest_reg_idx  (id_dest_reg_idx),
		.id_funct3        (id_funct3),
		.id_imm           (id_imm),
		.id_rd_mem        (id_rd_mem),
		.id_wr_mem        (id_wr_mem),
		.id_cond_branch   (id_cond_branch),
		.id_uncond_branch (id_uncond_branch),
		.id_csr_op        (id_csr_op),
		.id_halt          (id_halt),
		.id_illegal       (id_illegal)
	);

	////////////////////////////////////////
	// random source
	////////////////////////////////////////

	// galois lfsr, x^32+x^22+x^2+x+1, one step per bit handed out
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			r = {r[30:0], lfsr_state[0]};
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
			else
				lfsr_state = lfsr_state >> 1;
		end
		return r;
	endfunction

	// random fields everywhere, then the template fixes opcode and funct bits
	function automatic logic [31:0] make_word(input logic [31:0] pick);
		logic [31:0] w;
		logic [31:0] r;
		w = take_bits(32);
		r = take_bits(2);
		case (pick)
			0: w[6:0] = OP_LUI;
			1: w[6:0] = OP_AUIPC;
			2: w[6:0] = OP_JAL;
			3: begin
				w[6:0] = OP_JALR;
				// mostly the legal funct3
				if (r[1:0] != 2'b11)
					w[14:12] = F3_JALR;
			end
			4: w[6:0] = OP_BRANCH;
			5: w[6:0] = OP_LOAD;
			6: w[6:0] = OP_STORE;
			7: begin
				w[6:0] = OP_IMM;
				// shifts need a sane funct7 most of the time
				if (r[1:0] == 2'b00)
					w[31:25] = F7_BASE;
				else if (r[1:0] == 2'b01)
					w[31:25] = F7_ALT;
			end
			8: begin
				w[6:0] = OP_REG;
				w[31:25] = F7_BASE;
			end
			9: begin
				w[6:0] = OP_REG;
				w[31:25] = F7_ALT;
			end
			10: begin
				w[6:0] = OP_REG;
				w[31:25] = F7_MULDIV;
			end
			// low bits 00 is never a 32-bit opcode
			11: w[1:0] = 2'b00;
			12: begin
				// funct7 bit 1 set rules out all three legal values
				w[6:0] = OP_REG;
				w[26] = 1'b1;
			end
			13: w = WFI_WORD;
			14: begin
				w[6:0] = OP_SYSTEM;
				if (r[1:0] == 2'b00)
					w[14:12] = F3_CSRRW;
				else if (r[1:0] == 2'b01)
					w[14:12] = F3_CSRRS;
				else
					w[14:12] = F3_CSRRC;
			end
			default: w[6:0] = OP_SYSTEM;
		endcase
		return w;
	endfunction

	////////////////////////////////////////
	// reference decode model
	////////////////////////////////////////

	// shared op/op-imm funct3 table, alt turns add into sub and srl into sra
	function automatic logic [ALU_W-1:0] alu_for(input logic [2:0] f3, input logic alt);
		logic [ALU_W-1:0] fn;
		case (f3)
			3'd0: fn = alt ? ALU_SUB : ALU_ADD;
			3'd1: fn = ALU_SLL;
			3'd2: fn = ALU_SLT;
			3'd3: fn = ALU_SLTU;
			3'd4: fn = ALU_XOR;
			3'd5: fn = alt ? ALU_SRA : ALU_SRL;
			3'd6: fn = ALU_OR;
			default: fn = ALU_AND;
		endcase
		return fn;
	endfunction

	// fills the expected register from one word, pc and valid
	task automatic reference_decode(input logic [31:0] w, input logic [XLEN-1:0] pc,
			input logic v);
		logic [6:0]       op;
		logic [2:0]       f3;
		logic [6:0]       f7;
		logic             writes;
		logic [XLEN-1:0]  imm_i;
		logic [XLEN-1:0]  imm_s;
		logic [XLEN-1:0]  imm_b;
		logic [XLEN-1:0]  imm_u;
		logic [XLEN-1:0]  imm_j;
		op = w[6:0];
		f3 = w[14:12];
		f7 = w[31:25];
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
		imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		imm_u = {w[31:12], 12'h000};
		imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		// raw fields pass through whatever the class
		exp_pc = pc;
		exp_rs1 = w[19:15];
		exp_rs2 = w[24:20];
		exp_funct3 = f3;
		// noop unless a class says otherwise
		exp_opa = OPA_IS_RS1;
		exp_opb = OPB_IS_RS2;
		exp_alu = ALU_ADD;
		exp_fu = FU_ALU;
		exp_imm = '0;
		exp_rd_mem = 1'b0;
		exp_wr_mem = 1'b0;
		exp_cond = 1'b0;
		exp_uncond = 1'b0;
		exp_csr = 1'b0;
		exp_halt = 1'b0;
		exp_illegal = 1'b0;
		writes = 1'b0;
		if (v) begin
			case (op)
				OP_LUI, OP_AUIPC: begin
					writes = 1'b1;
					exp_opa = (op == OP_LUI) ? OPA_IS_ZERO : OPA_IS_PC;
					exp_opb = OPB_IS_U_IMM;
					exp_imm = imm_u;
				end
				OP_JAL: begin
					writes = 1'b1;
					exp_opa = OPA_IS_PC;
					exp_opb = OPB_IS_J_IMM;
					exp_imm = imm_j;
					exp_uncond = 1'b1;
					exp_fu = FU_BRANCH;
				end
				OP_JALR: begin
					if (f3 == 3'd0) begin
						writes = 1'b1;
						exp_opb = OPB_IS_I_IMM;
						exp_imm = imm_i;
						exp_uncond = 1'b1;
						exp_fu = FU_BRANCH;
					end else begin
						exp_illegal = 1'b1;
					end
				end
				OP_BRANCH: begin
					// 010 and 011 are the two holes in the compare table
					if (f3 != 3'd2 && f3 != 3'd3) begin
						exp_opa = OPA_IS_PC;
						exp_opb = OPB_IS_B_IMM;
						exp_imm = imm_b;
						exp_cond = 1'b1;
						exp_fu = FU_BRANCH;
					end else begin
						exp_illegal = 1'b1;
					end
				end
				OP_LOAD: begin
					if (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) begin
						writes = 1'b1;
						exp_opb = OPB_IS_I_IMM;
						exp_imm = imm_i;
						exp_rd_mem = 1'b1;
						exp_fu = FU_MEM;
					end else begin
						exp_illegal = 1'b1;
					end
				end
				OP_STORE: begin
					if (f3 <= 3'd2) begin
						exp_opb = OPB_IS_S_IMM;
						exp_imm = imm_s;
						exp_wr_mem = 1'b1;
						exp_fu = FU_MEM;
					end else begin
						exp_illegal = 1'b1;
					end
				end
				OP_IMM: begin
					// only the shift forms constrain imm[11:5]
					if ((f3 == 3'd1 && f7 != F7_BASE) ||
							(f3 == 3'd5 && f7 != F7_BASE && f7 != F7_ALT)) begin
						exp_illegal = 1'b1;
					end else begin
						writes = 1'b1;
						exp_opb = OPB_IS_I_IMM;
						exp_imm = imm_i;
						exp_alu = alu_for(f3, f3 == 3'd5 && f7 == F7_ALT);
					end
				end
				OP_REG: begin
					if (f7 == F7_BASE) begin
						writes = 1'b1;
						exp_alu = alu_for(f3, 1'b0);
					end else if (f7 == F7_ALT && (f3 == 3'd0 || f3 == 3'd5)) begin
						writes = 1'b1;
						exp_alu = alu_for(f3, 1'b1);
					end else if (f7 == F7_MULDIV && !f3[2]) begin
						// mul, mulh, mulhsu, mulhu in funct3 order
						writes = 1'b1;
						exp_fu = FU_MUL;
						case (f3[1:0])
							2'd0: exp_alu = ALU_MUL;
							2'd1: exp_alu = ALU_MULH;
							2'd2: exp_alu = ALU_MULHSU;
							default: exp_alu = ALU_MULHU;
						endcase
					end else begin
						exp_illegal = 1'b1;
					end
				end
				OP_SYSTEM: begin
					if (w == WFI_WORD)
						exp_halt = 1'b1;
					else if (f3 inside {3'd1, 3'd2, 3'd3})
						exp_csr = 1'b1;
					else
						exp_illegal = 1'b1;
				end
				default: exp_illegal = 1'b1;
			endcase
		end
		exp_dest = writes ? w[11:7] : 5'd0;
		exp_valid = v && !exp_illegal;
	endtask

	// a zero word without valid decodes to the all-zero reset state
	always @(posedge clock) begin
		if (reset)
			reference_decode('0, '0, 1'b0);
		else if (!stall)
			reference_decode(if_inst, if_pc, if_valid);
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	task automatic note_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		errors++;
		$display("Fail %s: got %h expected %h", name, got, exp);
	endtask

	// sampled on the falling edge, halfway between register updates
	a_valid: assert property (@(negedge clock) disable iff (reset)
		id_valid == exp_valid)
		else note_mismatch("id_valid", 32'(id_valid), 32'(exp_valid));
	a_pc: assert property (@(negedge clock) disable iff (reset)
		id_pc == exp_pc)
		else note_mismatch("id_pc", id_pc, exp_pc);
	a_opa: assert property (@(negedge clock) disable iff (reset)
		id_opa_select == exp_opa)
		else note_mismatch("id_opa_select", 32'(id_opa_select), 32'(exp_opa));
	a_opb: assert property (@(negedge clock) disable iff (reset)
		id_opb_select == exp_opb)
		else note_mismatch("id_opb_select", 32'(id_opb_select), 32'(exp_opb));
	a_alu: assert property (@(negedge clock) disable iff (reset)
		id_alu_func == exp_alu)
		else note_mismatch("id_alu_func", 32'(id_alu_func), 32'(exp_alu));
	a_fu: assert property (@(negedge clock) disable iff (reset)
		id_fu_type == exp_fu)
		else note_mismatch("id_fu_type", 32'(id_fu_type), 32'(exp_fu));
	a_rs1: assert property (@(negedge clock) disable iff (reset)
		id_rs1_idx == exp_rs1)
		else note_mismatch("id_rs1_idx", 32'(id_rs1_idx), 32'(exp_rs1));
	a_rs2: assert property (@(negedge clock) disable iff (reset)
		id_rs2_idx == exp_rs2)
		else note_mismatch("id_rs2_idx", 32'(id_rs2_idx), 32'(exp_rs2));
	a_dest: assert property (@(negedge clock) disable iff (reset)
		id_dest_reg_idx == exp_dest)
		else note_mismatch("id_dest_reg_idx", 32'(id_dest_reg_idx), 32'(exp_dest));
	a_funct3: assert property (@(negedge clock) disable iff (reset)
		id_funct3 == exp_funct3)
		else note_mismatch("id_funct3", 32'(id_funct3), 32'(exp_funct3));
	a_imm: assert property (@(negedge clock) disable iff (reset)
		id_imm == exp_imm)
		else note_mismatch("id_imm", id_imm, exp_imm);
	a_rd_mem: assert property (@(negedge clock) disable iff (reset)
		id_rd_mem == exp_rd_mem)
		else note_mismatch("id_rd_mem", 32'(id_rd_mem), 32'(exp_rd_mem));
	a_wr_mem: assert property (@(negedge clock) disable iff (reset)
		id_wr_mem == exp_wr_mem)
		else note_mismatch("id_wr_mem", 32'(id_wr_mem), 32'(exp_wr_mem));
	a_cond: assert property (@(negedge clock) disable iff (reset)
		id_cond_branch == exp_cond)
		else note_mismatch("id_cond_branch", 32'(id_cond_branch), 32'(exp_cond));
	a_uncond: assert property (@(negedge clock) disable iff (reset)
		id_uncond_branch == exp_uncond)
		else note_mismatch("id_uncond_branch", 32'(id_uncond_branch), 32'(exp_uncond));
	a_csr: assert property (@(negedge clock) disable iff (reset)
		id_csr_op == exp_csr)
		else note_mismatch("id_csr_op", 32'(id_csr_op), 32'(exp_csr));
	a_halt: assert property (@(negedge clock) disable iff (reset)
		id_halt == exp_halt)
		else note_mismatch("id_halt", 32'(id_halt), 32'(exp_halt));
	a_illegal: assert property (@(negedge clock) disable iff (reset)
		id_illegal == exp_illegal)
		else note_mismatch("id_illegal", 32'(id_illegal), 32'(exp_illegal));

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	// word goes out with stall high for hold edges, taken on the first free edge
	task automatic present(input logic [31:0] w, input logic v, input int hold);
		logic [31:0] r;
		r = take_bits(30);
		@(posedge clock);
		if_inst  <= w;
		if_pc    <= {r[29:0], 2'b00};
		if_valid <= v;
		stall    <= (hold > 0);
		words++;
		if (hold > 0) begin
			repeat (hold) @(posedge clock);
			stall <= 1'b0;
		end
	endtask

	task automatic directed_cases();
		present({20'h12345, 5'd5, OP_LUI}, 1'b1, 0);
		present({20'hfffff, 5'd6, OP_AUIPC}, 1'b1, 0);
		present({1'b1, 10'h155, 1'b1, 8'haa, 5'd1, OP_JAL}, 1'b1, 0);
		present({12'h800, 5'd2, F3_JALR, 5'd1, OP_JALR}, 1'b1, 0);
		present({7'h7f, 5'd3, 5'd4, F3_BNE, 5'h1f, OP_BRANCH}, 1'b1, 0);
		present({12'h7ff, 5'd8, F3_LBU, 5'd9, OP_LOAD}, 1'b1, 0);
		present({7'h40, 5'd10, 5'd11, F3_SW, 5'd12, OP_STORE}, 1'b1, 0);
		present({F7_ALT, 5'd3, 5'd7, F3_SR, 5'd13, OP_IMM}, 1'b1, 0);
		present({F7_ALT, 5'd14, 5'd15, F3_ADD, 5'd16, OP_REG}, 1'b1, 0);
		present({F7_MULDIV, 5'd17, 5'd18, F3_MULHU, 5'd19, OP_REG}, 1'b1, 0);
		// divide and a stray funct7 are outside the subset
		present({F7_MULDIV, 5'd1, 5'd2, 3'b100, 5'd3, OP_REG}, 1'b1, 0);
		present({7'h7f, 5'd1, 5'd2, F3_ADD, 5'd3, OP_REG}, 1'b1, 0);
		present(32'hffff_ffff, 1'b1, 0);
		present(WFI_WORD, 1'b1, 0);
		present({12'h300, 5'd1, F3_CSRRS, 5'd5, OP_SYSTEM}, 1'b1, 0);
		// ecall
		present(32'h0000_0073, 1'b1, 0);
		present({12'h123, 5'd1, F3_ADD, 5'd2, OP_IMM}, 1'b0, 0);
		present({1'b0, 10'h2aa, 1'b0, 8'h55, 5'd7, OP_JAL}, 1'b1, 5);
		present({20'h0abcd, 5'd9, OP_LUI}, 1'b1, 0);
	endtask

	always @(posedge clock)
		cycles <= cycles + 1;

	initial begin
		wait (cycles >= CYCLE_LIMIT);
		$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		logic [31:0] pick;
		logic [31:0] w;
		logic [31:0] r;
		int          hold;
		// a live jump sits at the input during reset, the register must still clear
		if_inst  = {1'b1, 10'h3c3, 1'b0, 8'h5a, 5'd21, OP_JAL};
		if_pc    = 32'h0000_1ff4;
		if_valid = 1'b1;
		stall    = 1'b0;
		@(posedge clock);
		while (reset)
			@(posedge clock);
		// back to idle before the directed words
		present('0, 1'b0, 0);
		directed_cases();
		for (int n = 0; n < NUM_RANDOM; n++) begin
			pick = take_bits(4);
			w = make_word(pick);
			r = take_bits(3);
			hold = 0;
			// about one word in eight waits behind a short stall
			if (r == 0)
				hold = 1 + take_bits(2);
			r = take_bits(3);
			present(w, r != 0, hold);
		end
		present('0, 1'b0, 0);
		repeat (3) @(posedge clock);
		$display("id_stage_tb: %0d words driven, %0d errors", words, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/decoder.sv
// control decoder for rv32im
// maps one instruction word to the datapath controls, noop when not valid

`default_nettype none

module decoder
	import sys_defs_pkg::*;
(
	input  inst_t             inst,
	// when low the word is ignored and every control is noop
	input  logic              valid_inst_in,
	output logic [OPA_W-1:0]  opa_select,
	output logic [OPB_W-1:0]  opb_select,
	output logic              dest_reg,
	output logic [ALU_W-1:0]  alu_func,
	output logic [FU_W-1:0]   fu_type,
	output logic              rd_mem,
	output logic              wr_mem,
	output logic              cond_branch,
	output logic              uncond_branch,
	output logic              csr_op,
	output logic              halt,
	output logic              illegal,
	output logic              valid_inst
);

	logic [ALU_W-1:0] base_alu;
	logic [ALU_W-1:0] mul_alu;
	logic [ALU_W-1:0] reg_alu;
	logic             mul_ok;
	logic             imm_ok;
	logic             reg_ok;

	// a halt is still a valid instruction, only illegal drops it
	assign valid_inst = valid_inst_in & ~illegal;

	////////////////////////////////////////
	// alu function from funct3/funct7
	////////////////////////////////////////

	// funct7 only matters for the right shifts here
	always_comb begin
		base_alu = ALU_ADD;
		case (inst.r.funct3)
			F3_ADD:  base_alu = ALU_ADD;
			F3_SLL:  base_alu = ALU_SLL;
			F3_SLT:  base_alu = ALU_SLT;
			F3_SLTU: base_alu = ALU_SLTU;
			F3_XOR:  base_alu = ALU_XOR;
			F3_SR:   base_alu = (inst.r.funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
			F3_OR:   base_alu = ALU_OR;
			F3_AND:  base_alu = ALU_AND;
		endcase
	end

	// multiply variants, upper funct3 values are divides
	assign mul_ok = inst.r.funct3 inside {F3_MUL, F3_MULH, F3_MULHSU, F3_MULHU};

	always_comb begin
		mul_alu = ALU_MUL;
		case (inst.r.funct3)
			F3_MULH:   mul_alu = ALU_MULH;
			F3_MULHSU: mul_alu = ALU_MULHSU;
			F3_MULHU:  mul_alu = ALU_MULHU;
			default:   mul_alu = ALU_MUL;
		endcase
	end

	// shift immediates carry funct7 in imm[11:5], everything else is free
	assign imm_ok = !(inst.r.funct3 inside {F3_SLL, F3_SR}) ||
		(inst.r.funct7 == F7_BASE) ||
		(inst.r.funct3 == F3_SR && inst.r.funct7 == F7_ALT);

	// register-register forms
	always_comb begin
		reg_ok  = 1'b0;
		reg_alu = base_alu;
		case (inst.r.funct7)
			F7_BASE: reg_ok = 1'b1;
			F7_ALT: begin
				// alt selects sub and sra only
				reg_ok = (inst.r.funct3 == F3_ADD) || (inst.r.funct3 == F3_SR);
				if (inst.r.funct3 == F3_ADD)
					reg_alu = ALU_SUB;
			end
			F7_MULDIV: begin
				reg_ok  = mul_ok;
				reg_alu = mul_alu;
			end
			default: reg_ok = 1'b0;
		endcase
	end

	////////////////////////////////////////
	// instruction class
	////////////////////////////////////////

	always_comb begin
		// noop defaults, a class only touches what it needs
		opa_select    = OPA_IS_RS1;
		opb_select    = OPB_IS_RS2;
		dest_reg      = DEST_NONE;
		alu_func      = ALU_ADD;
		fu_type       = FU_ALU;
		rd_mem        = 1'b0;
		wr_mem        = 1'b0;
		cond_branch   = 1'b0;
		uncond_branch = 1'b0;
		csr_op        = 1'b0;
		halt          = 1'b0;
		illegal       = 1'b0;
		if (valid_inst_in) begin
			case (inst.r.opcode)
				OP_LUI: begin
					dest_reg   = DEST_RD;
					opa_select = OPA_IS_ZERO;
					opb_select = OPB_IS_U_IMM;
				end
				OP_AUIPC: begin
					dest_reg   = DEST_RD;
					opa_select = OPA_IS_PC;
					opb_select = OPB_IS_U_IMM;
				end
				OP_JAL: begin
					// target computed as pc + j offset
					dest_reg      = DEST_RD;
					opa_select    = OPA_IS_PC;
					opb_select    = OPB_IS_J_IMM;
					uncond_branch = 1'b1;
					fu_type       = FU_BRANCH;
				end
				OP_JALR: begin
					if (inst.r.funct3 == F3_JALR) begin
						dest_reg      = DEST_RD;
						opb_select    = OPB_IS_I_IMM;
						uncond_branch = 1'b1;
						fu_type       = FU_BRANCH;
					end else begin
						illegal = 1'b1;
					end
				end
				OP_BRANCH: begin
					if (inst.r.funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE,
							F3_BLTU, F3_BGEU}) begin
						opa_select  = OPA_IS_PC;
						opb_select  = OPB_IS_B_IMM;
						cond_branch = 1'b1;
						fu_type     = FU_BRANCH;
					end else begin
						illegal = 1'b1;
					end
				end
				OP_LOAD: begin
					if (inst.r.funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU}) begin
						dest_reg   = DEST_RD;
						opb_select = OPB_IS_I_IMM;
						rd_mem     = 1'b1;
						fu_type    = FU_MEM;
					end else begin
						illegal = 1'b1;
					end
				end
				OP_STORE: begin
					if (inst.r.funct3 inside {F3_SB, F3_SH, F3_SW}) begin
						opb_select = OPB_IS_S_IMM;
						wr_mem     = 1'b1;
						fu_type    = FU_MEM;
					end else begin
						illegal = 1'b1;
					end
				end
				OP_IMM: begin
					if (imm_ok) begin
						dest_reg   = DEST_RD;
						opb_select = OPB_IS_I_IMM;
						alu_func   = base_alu;
					end else begin
						illegal = 1'b1;
					end
				end
				OP_REG: begin
					if (reg_ok) begin
						dest_reg = DEST_RD;
						alu_func = reg_alu;
						fu_type  = (inst.r.funct7 == F7_MULDIV) ? FU_MUL : FU_ALU;
					end else begin
						illegal = 1'b1;
					end
				end
				OP_SYSTEM: begin
					// wfi first, it shares the system opcode
					if (inst == WFI_WORD)
						halt = 1'b1;
					else if (inst.r.funct3 inside {F3_CSRRW, F3_CSRRS, F3_CSRRC})
						csr_op = 1'b1;
					else
						illegal = 1'b1;
				end
				default: illegal = 1'b1;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/id_stage.sv
// decode stage top
// runs the control decoder and immediate generator on one word, holds the id/ex register

`default_nettype none

module id_stage
	import sys_defs_pkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  inst_t                 if_inst,
	input  logic [XLEN-1:0]       if_pc,
	input  logic                  if_valid,
	// hold the id/ex register
	input  logic                  stall,
	output logic                  id_valid,
	output logic [XLEN-1:0]       id_pc,
	output logic [OPA_W-1:0]      id_opa_select,
	output logic [OPB_W-1:0]      id_opb_select,
	output logic [ALU_W-1:0]      id_alu_func,
	output logic [FU_W-1:0]       id_fu_type,
	output logic [REG_IDX_W-1:0]  id_rs1_idx,
	output logic [REG_IDX_W-1:0]  id_rs2_idx,
	output logic [REG_IDX_W-1:0]  id_dest_reg_idx,
	output logic [2:0]            id_funct3,
	output logic [XLEN-1:0]       id_imm,
	output logic                  id_rd_mem,
	output logic                  id_wr_mem,
	output logic                  id_cond_branch,
	output logic                  id_uncond_branch,
	output logic                  id_csr_op,
	output logic                  id_halt,
	output logic                  id_illegal
);

	// decoder outputs
	logic [OPA_W-1:0]      opa_select;
	logic [OPB_W-1:0]      opb_select;
	logic                  dest_reg;
	logic [ALU_W-1:0]      alu_func;
	logic [FU_W-1:0]       fu_type;
	logic                  rd_mem;
	logic                  wr_mem;
	logic                  cond_branch;
	logic                  uncond_branch;
	logic                  csr_op;
	logic                  halt;
	logic                  illegal;
	logic                  valid_inst;

	// immediate candidates
	logic [XLEN-1:0]       i_imm;
	logic [XLEN-1:0]       s_imm;
	logic [XLEN-1:0]       b_imm;
	logic [XLEN-1:0]       u_imm;
	logic [XLEN-1:0]       j_imm;

	logic [XLEN-1:0]       imm_sel;
	logic [REG_IDX_W-1:0]  dest_idx;

	decoder u_decoder (
		.inst          (if_inst),
		.valid_inst_in (if_valid),
		.opa_select    (opa_select),
		.opb_select    (opb_select),
		.dest_reg      (dest_reg),
		.alu_func      (alu_func),
		.fu_type       (fu_type),
		.rd_mem        (rd_mem),
		.wr_mem        (wr_mem),
		.cond_branch   (cond_branch),
		.uncond_branch (uncond_branch),
		.csr_op        (csr_op),
		.halt          (halt),
		.illegal       (illegal),
		.valid_inst    (valid_inst)
	);

	imm_gen u_imm_gen (
		.inst  (if_inst),
		.i_imm (i_imm),
		.s_imm (s_imm),
		.b_imm (b_imm),
		.u_imm (u_imm),
		.j_imm (j_imm)
	);

	////////////////////////////////////////
	// combine decoder and immediates
	////////////////////////////////////////

	// operand b select also picks the immediate format
	always_comb begin
		case (opb_select)
			OPB_IS_RS2:   imm_sel = '0;
			OPB_IS_I_IMM: imm_sel = i_imm;
			OPB_IS_S_IMM: imm_sel = s_imm;
			OPB_IS_B_IMM: imm_sel = b_imm;
			OPB_IS_U_IMM: imm_sel = u_imm;
			OPB_IS_J_IMM: imm_sel = j_imm;
			default:      imm_sel = '0;
		endcase
	end

	// x0 as destination when nothing is written back
	assign dest_idx = (dest_reg == DEST_RD) ? if_inst.r.rd : '0;

	////////////////////////////////////////
	// id/ex register
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			id_valid         <= 1'b0;
			id_pc            <= '0;
			id_opa_select    <= '0;
			id_opb_select    <= '0;
			id_alu_func      <= '0;
			id_fu_type       <= '0;
			id_rs1_idx       <= '0;
			id_rs2_idx       <= '0;
			id_dest_reg_idx  <= '0;
			id_funct3        <= '0;
			id_imm           <= '0;
			id_rd_mem        <= 1'b0;
			id_wr_mem        <= 1'b0;
			id_cond_branch   <= 1'b0;
			id_uncond_branch <= 1'b0;
			id_csr_op        <= 1'b0;
			id_halt          <= 1'b0;
			id_illegal       <= 1'b0;
		end else if (!stall) begin
			// take the word on every unstalled edge
			id_valid         <= valid_inst;
			id_pc            <= if_pc;
			id_opa_select    <= opa_select;
			id_opb_select    <= opb_select;
			id_alu_func      <= alu_func;
			id_fu_type       <= fu_type;
			id_rs1_idx       <= if_inst.r.rs1;
			id_rs2_idx       <= if_inst.r.rs2;
			id_dest_reg_idx  <= dest_idx;
			id_funct3        <= if_inst.r.funct3;
			id_imm           <= imm_sel;
			id_rd_mem        <= rd_mem;
			id_wr_mem        <= wr_mem;
			id_cond_branch   <= cond_branch;
			id_uncond_branch <= uncond_branch;
			id_csr_op        <= csr_op;
			id_halt          <= halt;
			id_illegal       <= illegal;
		end
	end

endmodule

`default_nettype wire

// File: verilog/imm_gen.sv
// immediate generator
// rebuilds the i, s, b, u and j immediates of one word, sign extended

`default_nettype none

module imm_gen
	import sys_defs_pkg::*;
(
	input  inst_t            inst,
	output logic [XLEN-1:0]  i_imm,
	output logic [XLEN-1:0]  s_imm,
	output logic [XLEN-1:0]  b_imm,
	output logic [XLEN-1:0]  u_imm,
	output logic [XLEN-1:0]  j_imm
);

	////////////////////////////////////////
	// contiguous formats
	////////////////////////////////////////

	// i type, imm[11] is bit 31 of the word
	assign i_imm = {{(XLEN-12){inst.i.imm[11]}}, inst.i.imm};

	// s type splits the offset around rs2/rs1/funct3
	assign s_imm = {{(XLEN-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};

	// u type fills the upper 20 bits, nothing to extend
	assign u_imm = {inst.u.imm, 12'b0};

	////////////////////////////////////////
	// scattered offsets, bit 0 always zero
	////////////////////////////////////////

	// b type, +/- 4 KiB branch range
	assign b_imm = {
		{(XLEN-13){inst.b.imm_12}},
		inst.b.imm_12,
		inst.b.imm_11,
		inst.b.imm_10_5,
		inst.b.imm_4_1,
		1'b0
	};

	// j type, +/- 1 MiB jump range
	assign j_imm = {
		{(XLEN-21){inst.j.imm_20}},
		inst.j.imm_20,
		inst.j.imm_19_12,
		inst.j.imm_11,
		inst.j.imm_10_1,
		1'b0
	};

endmodule

`default_nettype wire

// File: verilog/sys_defs_pkg.sv
// shared definitions for the rv32im decode stage
// widths, opcode and funct encodings, datapath select codes, instruction views

`default_nettype none

package sys_defs_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	localparam int XLEN      = 32;
	localparam int REG_IDX_W = 5;
	localparam int OPA_W     = 2;
	localparam int OPB_W     = 3;
	localparam int ALU_W     = 5;
	localparam int FU_W      = 2;

	////////////////////////////////////////
	// opcodes and funct fields
	////////////////////////////////////////

	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	// only legal funct7 values in rv32im
	localparam logic [6:0] F7_BASE   = 7'b0000000;
	localparam logic [6:0] F7_ALT    = 7'b0100000;
	localparam logic [6:0] F7_MULDIV = 7'b0000001;

	// wfi is matched on the whole word
	localparam logic [31:0] WFI_WORD = 32'h1050_0073;

	localparam logic [2:0] F3_JALR   = 3'b000;

	// branch compares
	localparam logic [2:0] F3_BEQ    = 3'b000;
	localparam logic [2:0] F3_BNE    = 3'b001;
	localparam logic [2:0] F3_BLT    = 3'b100;
	localparam logic [2:0] F3_BGE    = 3'b101;
	localparam logic [2:0] F3_BLTU   = 3'b110;
	localparam logic [2:0] F3_BGEU   = 3'b111;

	// load and store sizes
	localparam logic [2:0] F3_LB     = 3'b000;
	localparam logic [2:0] F3_LH     = 3'b001;
	localparam logic [2:0] F3_LW     = 3'b010;
	localparam logic [2:0] F3_LBU    = 3'b100;
	localparam logic [2:0] F3_LHU    = 3'b101;
	localparam logic [2:0] F3_SB     = 3'b000;
	localparam logic [2:0] F3_SH     = 3'b001;
	localparam logic [2:0] F3_SW     = 3'b010;

	// alu ops, shared by op and op-imm
	localparam logic [2:0] F3_ADD    = 3'b000;
	localparam logic [2:0] F3_SLL    = 3'b001;
	localparam logic [2:0] F3_SLT    = 3'b010;
	localparam logic [2:0] F3_SLTU   = 3'b011;
	localparam logic [2:0] F3_XOR    = 3'b100;
	localparam logic [2:0] F3_SR     = 3'b101;
	localparam logic [2:0] F3_OR     = 3'b110;
	localparam logic [2:0] F3_AND    = 3'b111;

	// multiplies under F7_MULDIV, divides are not supported
	localparam logic [2:0] F3_MUL    = 3'b000;
	localparam logic [2:0] F3_MULH   = 3'b001;
	localparam logic [2:0] F3_MULHSU = 3'b010;
	localparam logic [2:0] F3_MULHU  = 3'b011;

	// register forms of csr access only
	localparam logic [2:0] F3_CSRRW  = 3'b001;
	localparam logic [2:0] F3_CSRRS  = 3'b010;
	localparam logic [2:0] F3_CSRRC  = 3'b011;

	////////////////////////////////////////
	// datapath select codes
	////////////////////////////////////////

	localparam logic [OPA_W-1:0] OPA_IS_RS1  = 2'd0;
	localparam logic [OPA_W-1:0] OPA_IS_PC   = 2'd1;
	localparam logic [OPA_W-1:0] OPA_IS_ZERO = 2'd2;

	localparam logic [OPB_W-1:0] OPB_IS_RS2   = 3'd0;
	localparam logic [OPB_W-1:0] OPB_IS_I_IMM = 3'd1;
	localparam logic [OPB_W-1:0] OPB_IS_S_IMM = 3'd2;
	localparam logic [OPB_W-1:0] OPB_IS_B_IMM = 3'd3;
	localparam logic [OPB_W-1:0] OPB_IS_U_IMM = 3'd4;
	localparam logic [OPB_W-1:0] OPB_IS_J_IMM = 3'd5;

	localparam logic DEST_NONE = 1'b0;
	localparam logic DEST_RD   = 1'b1;

	localparam logic [ALU_W-1:0] ALU_ADD    = 5'd0;
	localparam logic [ALU_W-1:0] ALU_SUB    = 5'd1;
	localparam logic [ALU_W-1:0] ALU_SLT    = 5'd2;
	localparam logic [ALU_W-1:0] ALU_SLTU   = 5'd3;
	localparam logic [ALU_W-1:0] ALU_AND    = 5'd4;
	localparam logic [ALU_W-1:0] ALU_OR     = 5'd5;
	localparam logic [ALU_W-1:0] ALU_XOR    = 5'd6;
	localparam logic [ALU_W-1:0] ALU_SLL    = 5'd7;
	localparam logic [ALU_W-1:0] ALU_SRL    = 5'd8;
	localparam logic [ALU_W-1:0] ALU_SRA    = 5'd9;
	localparam logic [ALU_W-1:0] ALU_MUL    = 5'd10;
	localparam logic [ALU_W-1:0] ALU_MULH   = 5'd11;
	localparam logic [ALU_W-1:0] ALU_MULHSU = 5'd12;
	localparam logic [ALU_W-1:0] ALU_MULHU  = 5'd13;

	localparam logic [FU_W-1:0] FU_ALU    = 2'd0;
	localparam logic [FU_W-1:0] FU_MEM    = 2'd1;
	localparam logic [FU_W-1:0] FU_BRANCH = 2'd2;
	localparam logic [FU_W-1:0] FU_MUL    = 2'd3;

	////////////////////////////////////////
	// instruction word, one view per format
	////////////////////////////////////////

	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s;
		// branch offset bits are scattered around rs2/rs1/funct3
		struct packed {
			logic       imm_12;
			logic [5:0] imm_10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm_4_1;
			logic       imm_11;
			logic [6:0] opcode;
		} b;
		struct packed {
			logic [19:0] imm;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u;
		struct packed {
			logic       imm_20;
			logic [9:0] imm_10_1;
			logic       imm_11;
			logic [7:0] imm_19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;
	} inst_t;

endpackage

`default_nettype wire
